// ==== Makefile ====
SOURCES := $(wildcard design/*.sv) test/timetag_tb.sv

all: run

obj_dir/Vtimetag_tb: all.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module timetag_tb

run: obj_dir/Vtimetag_tb
	./obj_dir/Vtimetag_tb | tee sim.log
	grep -qx "TEST OK" sim.log

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module timetag

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// ==== all.f ====
design/tt_cmd_pkg.sv
design/tt_rec_pkg.sv
design/tt_cmd_if.sv
design/cmd_parser.sv
design/reg_bank.sv
design/pulse_seq.sv
design/strobe_tagger.sv
design/record_fifo.sv
design/record_serializer.sv
design/timetag.sv
test/timetag_tb.sv

// ==== design/cmd_parser.sv ====
`timescale 1ns/1ns

module cmd_parser (
	input  logic       clk,
	input  logic       rst,
	input  logic       cmd_wr,
	input  logic [7:0] cmd_in,
	tt_cmd_if.src      cmd
);

	tt_cmd_pkg::parser_state_e state;
	logic [7:0] len;
	// Payload bytes taken after the opcode
	logic [7:0] cnt;
	logic       frame_ok;
	logic [1:0] byte_sel;

	// Value bytes follow the address byte, least significant first
	assign byte_sel = cnt[1:0] - 2'd1;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= tt_cmd_pkg::ST_SYNC;
			len       <= '0;
			cnt       <= '0;
			frame_ok  <= 1'b0;
			cmd.valid <= 1'b0;
		end else begin
			cmd.valid <= 1'b0;
			if (cmd_wr) begin
				case (state)
					tt_cmd_pkg::ST_SYNC: begin
						if (cmd_in == tt_cmd_pkg::SYNC_BYTE) begin
							state <= tt_cmd_pkg::ST_LEN;
						end
					end
					tt_cmd_pkg::ST_LEN: begin
						len <= cmd_in;
						// Empty frame has no opcode to read
						state <= (cmd_in == 8'd0) ? tt_cmd_pkg::ST_SYNC : tt_cmd_pkg::ST_OPCODE;
					end
					tt_cmd_pkg::ST_OPCODE: begin
						cmd.opcode <= tt_cmd_pkg::opcode_e'(cmd_in);
						cmd.value  <= '0;
						cnt        <= '0;
						// Unknown opcode or wrong length, frame is swallowed silently
						frame_ok <= (cmd_in == tt_cmd_pkg::OP_SET_RUN &&
							len == tt_cmd_pkg::LEN_SET_RUN) ||
							(cmd_in == tt_cmd_pkg::OP_WRITE_REG &&
							len == tt_cmd_pkg::LEN_WRITE_REG);
						state <= (len == 8'd1) ? tt_cmd_pkg::ST_SYNC : tt_cmd_pkg::ST_PAYLOAD;
					end
					tt_cmd_pkg::ST_PAYLOAD: begin
						if (frame_ok) begin
							if (cmd.opcode == tt_cmd_pkg::OP_WRITE_REG) begin
								if (cnt == 8'd0) begin
									cmd.addr <= cmd_in;
								end else begin
									cmd.value[8*byte_sel +: 8] <= cmd_in;
								end
							end else begin
								// SET_RUN mask
								cmd.value[7:0] <= cmd_in;
							end
						end
						cnt <= cnt + 8'd1;
						if (cnt == len - 8'd2) begin
							cmd.valid <= frame_ok;
							state     <= tt_cmd_pkg::ST_SYNC;
						end
					end
					default: state <= tt_cmd_pkg::ST_SYNC;
				endcase
			end
		end
	end

	a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		cmd.valid |=> !cmd.valid);

endmodule

// ==== design/pulse_seq.sv ====
`timescale 1ns/1ns

module pulse_seq #(
	parameter int COUNT_WIDTH = 32
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   run,
	input  logic [COUNT_WIDTH-1:0] initial_cnt,
	input  logic [COUNT_WIDTH-1:0] high_cnt,
	input  logic [COUNT_WIDTH-1:0] low_cnt,
	output logic                   laser_en
);

	typedef enum logic [1:0] {
		IDLE,
		DELAY,
		HIGH,
		LOW
	} seq_state_e;

	localparam logic [COUNT_WIDTH-1:0] ONE = COUNT_WIDTH'(1);

	seq_state_e             state;
	// Cycles left in the current phase
	logic [COUNT_WIDTH-1:0] cnt;

	// Zero would never expire, run it as a single cycle
	function automatic logic [COUNT_WIDTH-1:0] phase_len(input logic [COUNT_WIDTH-1:0] c);
		phase_len = (c == '0) ? ONE : c;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			cnt   <= '0;
		end else if (!run) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					state <= DELAY;
					cnt   <= phase_len(initial_cnt);
				end
				default: begin
					if (cnt == ONE) begin
						// Delay and low both lead into a high phase
						state <= (state == HIGH) ? LOW : HIGH;
						cnt   <= phase_len((state == HIGH) ? low_cnt : high_cnt);
					end else begin
						cnt <= cnt - ONE;
					end
				end
			endcase
		end
	end

	assign laser_en = (state == HIGH);

endmodule

// ==== design/record_fifo.sv ====
`timescale 1ns/1ns

module record_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   push,
	input  tt_rec_pkg::event_rec_t wr_rec,
	input  logic                   pop,
	output tt_rec_pkg::event_rec_t rd_rec,
	output logic                   empty,
	output logic                   overflow
);

	localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	tt_rec_pkg::event_rec_t mem [FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          full;
	logic          wr_en;
	logic          rd_en;

	assign empty = (count == '0);
	assign full  = (count == CW'(FIFO_DEPTH));
	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	// Head record is visible without a read cycle
	assign rd_rec = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_rec;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CW'(wr_en) - CW'(rd_en);
			// Dropped record, flag stays until reset
			if (push && full) begin
				overflow <= 1'b1;
			end
		end
	end

	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		pop |-> !empty);

endmodule

// ==== design/record_serializer.sv ====
`timescale 1ns/1ns

module record_serializer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   empty,
	input  tt_rec_pkg::event_rec_t rec,
	output logic                   pop,
	output logic [7:0]             data,
	output logic                   data_rdy,
	input  logic                   data_ack
);

	typedef enum logic [1:0] {
		P_IDLE,
		P_SETUP,
		P_RDY,
		P_RELEASE
	} phase_e;

	phase_e      phase;
	logic [1:0]  byte_idx;
	// Current byte always sits in the top eight bits
	logic [31:0] shift;

	assign pop      = (phase == P_IDLE) && !empty;
	assign data     = shift[31:24];
	assign data_rdy = (phase == P_RDY);

	always_ff @(posedge clk) begin
		if (rst) begin
			phase    <= P_IDLE;
			byte_idx <= '0;
		end else begin
			case (phase)
				P_IDLE: begin
					if (!empty) begin
						byte_idx <= '0;
						phase    <= P_SETUP;
					end
				end
				// data settles one cycle ahead of data_rdy
				P_SETUP: phase <= P_RDY;
				P_RDY: begin
					if (data_ack) begin
						phase <= P_RELEASE;
					end
				end
				P_RELEASE: begin
					// Receiver has dropped ack, byte is done
					if (!data_ack) begin
						byte_idx <= byte_idx + 2'd1;
						phase    <= (byte_idx == 2'd3) ? P_IDLE : P_SETUP;
					end
				end
				default: phase <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			shift <= rec;
		end else if (phase == P_RELEASE && !data_ack) begin
			shift <= {shift[23:0], 8'h00};
		end
	end

	a_data_stable: assert property (@(posedge clk) disable iff (rst)
		data_rdy |=> (!data_rdy || $stable(data)));

endmodule

// ==== design/reg_bank.sv ====
`timescale 1ns/1ns

module reg_bank #(
	parameter int N_SEQ       = 4,
	parameter int COUNT_WIDTH = 32
) (
	input  logic                              clk,
	input  logic                              rst,
	tt_cmd_if.dst                             cmd,
	output logic                              tagger_run,
	output logic                              pulse_run,
	output logic [N_SEQ-1:0][COUNT_WIDTH-1:0] initial_cnt,
	output logic [N_SEQ-1:0][COUNT_WIDTH-1:0] high_cnt,
	output logic [N_SEQ-1:0][COUNT_WIDTH-1:0] low_cnt
);

	always_ff @(posedge clk) begin
		if (rst) begin
			tagger_run  <= 1'b0;
			pulse_run   <= 1'b0;
			initial_cnt <= '0;
			high_cnt    <= '0;
			low_cnt     <= '0;
		end else if (cmd.valid) begin
			case (cmd.opcode)
				tt_cmd_pkg::OP_SET_RUN: begin
					tagger_run <= cmd.value[tt_cmd_pkg::RUN_TAGGER];
					pulse_run  <= cmd.value[tt_cmd_pkg::RUN_PULSE];
				end
				tt_cmd_pkg::OP_WRITE_REG: begin
					// Upper six address bits select the sequencer
					for (int i = 0; i < N_SEQ; i++) begin
						if (int'(cmd.addr[7:2]) == i) begin
							case ({6'd0, cmd.addr[1:0]})
								tt_cmd_pkg::REG_INITIAL: begin
									initial_cnt[i] <= cmd.value[COUNT_WIDTH-1:0];
								end
								tt_cmd_pkg::REG_HIGH: begin
									high_cnt[i] <= cmd.value[COUNT_WIDTH-1:0];
								end
								tt_cmd_pkg::REG_LOW: begin
									low_cnt[i] <= cmd.value[COUNT_WIDTH-1:0];
								end
								// Offset 3 unused
								default: ;
							endcase
						end
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== design/strobe_tagger.sv ====
`timescale 1ns/1ns

module strobe_tagger (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          run,
	input  logic [tt_rec_pkg::N_CHAN-1:0] strobe_in,
	output logic                          push,
	output tt_rec_pkg::event_rec_t        rec
);

	// Two-flop synchronizer, then the previous level for edge detect
	logic [tt_rec_pkg::N_CHAN-1:0]   sync_a;
	logic [tt_rec_pkg::N_CHAN-1:0]   sync_b;
	logic [tt_rec_pkg::N_CHAN-1:0]   prev;
	logic [tt_rec_pkg::N_CHAN-1:0]   rise;
	logic [tt_rec_pkg::TS_WIDTH-1:0] ts_cnt;

	assign rise = sync_b & ~prev;

	always_ff @(posedge clk) begin
		if (rst) begin
			sync_a <= '0;
			sync_b <= '0;
			prev   <= '0;
			ts_cnt <= '0;
			push   <= 1'b0;
		end else begin
			sync_a <= strobe_in;
			sync_b <= sync_a;
			prev   <= sync_b;
			// Free-running, wraps at 2**TS_WIDTH
			ts_cnt <= ts_cnt + 1'b1;
			// Simultaneous edges share one record
			push <= run && (rise != '0);
		end
	end

	always_ff @(posedge clk) begin
		rec.chan <= rise;
		rec.ts   <= ts_cnt;
	end

endmodule

// ==== design/timetag.sv ====
`timescale 1ns/1ns

module timetag #(
	parameter int FIFO_DEPTH  = 8,
	parameter int N_SEQ       = 4,
	parameter int COUNT_WIDTH = 32
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             cmd_wr,
	input  logic [7:0]       cmd_in,
	input  logic [3:0]       strobe_in,
	input  logic             data_ack,
	output logic [7:0]       data,
	output logic             data_rdy,
	output logic [N_SEQ-1:0] laser_en,
	output logic             overflow
);

	tt_cmd_if cmd_bus ();

	logic                              tagger_run;
	logic                              pulse_run;
	logic [N_SEQ-1:0][COUNT_WIDTH-1:0] initial_cnt;
	logic [N_SEQ-1:0][COUNT_WIDTH-1:0] high_cnt;
	logic [N_SEQ-1:0][COUNT_WIDTH-1:0] low_cnt;
	logic                              push;
	logic                              pop;
	logic                              empty;
	tt_rec_pkg::event_rec_t            tag_rec;
	tt_rec_pkg::event_rec_t            head_rec;

	cmd_parser u_parser (
		.clk    (clk),
		.rst    (rst),
		.cmd_wr (cmd_wr),
		.cmd_in (cmd_in),
		.cmd    (cmd_bus)
	);

	reg_bank #(
		.N_SEQ       (N_SEQ),
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_regs (
		.clk         (clk),
		.rst         (rst),
		.cmd         (cmd_bus),
		.tagger_run  (tagger_run),
		.pulse_run   (pulse_run),
		.initial_cnt (initial_cnt),
		.high_cnt    (high_cnt),
		.low_cnt     (low_cnt)
	);

	// One sequencer per laser enable
	for (genvar i = 0; i < N_SEQ; i++) begin : g_seq
		pulse_seq #(
			.COUNT_WIDTH (COUNT_WIDTH)
		) u_seq (
			.clk         (clk),
			.rst         (rst),
			.run         (pulse_run),
			.initial_cnt (initial_cnt[i]),
			.high_cnt    (high_cnt[i]),
			.low_cnt     (low_cnt[i]),
			.laser_en    (laser_en[i])
		);
	end

	strobe_tagger u_tagger (
		.clk       (clk),
		.rst       (rst),
		.run       (tagger_run),
		.strobe_in (strobe_in),
		.push      (push),
		.rec       (tag_rec)
	);

	record_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk      (clk),
		.rst      (rst),
		.push     (push),
		.wr_rec   (tag_rec),
		.pop      (pop),
		.rd_rec   (head_rec),
		.empty    (empty),
		.overflow (overflow)
	);

	record_serializer u_ser (
		.clk      (clk),
		.rst      (rst),
		.empty    (empty),
		.rec      (head_rec),
		.pop      (pop),
		.data     (data),
		.data_rdy (data_rdy),
		.data_ack (data_ack)
	);

endmodule

// ==== design/tt_cmd_if.sv ====
`timescale 1ns/1ns

interface tt_cmd_if;

	// One-cycle strobe, the fields below hold steady with it
	logic                  valid;
	tt_cmd_pkg::opcode_e   opcode;
	logic [7:0]            addr;
	logic [31:0]           value;

	modport src (
		output valid,
		output opcode,
		output addr,
		output value
	);

	modport dst (
		input valid,
		input opcode,
		input addr,
		input value
	);

endinterface

// ==== design/tt_cmd_pkg.sv ====
package tt_cmd_pkg;

	// Every command frame opens with this byte
	localparam logic [7:0] SYNC_BYTE = 8'hAA;

	typedef enum logic [7:0] {
		OP_SET_RUN   = 8'h01,
		OP_WRITE_REG = 8'h04
	} opcode_e;

	// Frame length byte, opcode included
	localparam logic [7:0] LEN_SET_RUN   = 8'd2;
	localparam logic [7:0] LEN_WRITE_REG = 8'd6;

	// Register offsets within one sequencer, address is 4 * seq + offset
	localparam logic [7:0] REG_INITIAL = 8'h00;
	localparam logic [7:0] REG_HIGH    = 8'h01;
	localparam logic [7:0] REG_LOW     = 8'h02;

	// Bit positions in the SET_RUN mask byte
	localparam int RUN_TAGGER = 0;
	localparam int RUN_PULSE  = 1;

	typedef enum logic [1:0] {
		ST_SYNC,
		ST_LEN,
		ST_OPCODE,
		ST_PAYLOAD
	} parser_state_e;

endpackage

// ==== design/tt_rec_pkg.sv ====
package tt_rec_pkg;

	// Detector inputs
	localparam int N_CHAN = 4;

	// Timestamp bits, the rest of the record is the channel mask
	localparam int TS_WIDTH = 28;

	// One tagged event, mask in the top nibble
	typedef struct packed {
		logic [N_CHAN-1:0]   chan;
		logic [TS_WIDTH-1:0] ts;
	} event_rec_t;

endpackage

// ==== test/timetag_tb.sv ====
`timescale 1ns/1ns

module timetag_tb;

	localparam int FIFO_DEPTH = 8;
	localparam int N_SEQ      = 4;
	// Far above the sum of all tests
	localparam int MAX_CYCLES = 20000;

	logic             clk;
	logic             rst;
	logic             cmd_wr;
	logic [7:0]       cmd_in;
	logic [3:0]       strobe_in;
	logic             data_ack;
	logic [7:0]       data;
	logic             data_rdy;
	logic [N_SEQ-1:0] laser_en;
	logic             overflow;

	int errors;
	int tests_passed;
	int tests_failed;
	int seed;
	int cycle_cnt = 0;

	timetag #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.N_SEQ       (N_SEQ),
		.COUNT_WIDTH (32)
	) uut (
		.clk       (clk),
		.rst       (rst),
		.cmd_wr    (cmd_wr),
		.cmd_in    (cmd_in),
		.strobe_in (strobe_in),
		.data_ack  (data_ack),
		.data      (data),
		.data_rdy  (data_rdy),
		.laser_en  (laser_en),
		.overflow  (overflow)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout, run stopped after %0d cycles", cycle_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic flag_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
		errors++;
	endtask

	task automatic flag_error(input string msg);
		$display("ERROR %s", msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int start);
		if (errors == start) begin
			tests_passed++;
			$display("%s passed", name);
		end else begin
			tests_failed++;
			$display("%s failed with %0d errors", name, errors - start);
		end
	endtask

	task automatic tick(input int n);
		repeat (n) @(posedge clk);
	endtask

	// One command byte per clock while cmd_wr is high
	task automatic send_byte(input logic [7:0] b);
		cmd_wr <= 1'b1;
		cmd_in <= b;
		@(posedge clk);
	endtask

	task automatic end_frame();
		cmd_wr <= 1'b0;
		cmd_in <= 8'h00;
	endtask

	task automatic send_set_run(input logic [7:0] mask);
		send_byte(8'hAA);
		send_byte(8'h02);
		send_byte(8'h01);
		send_byte(mask);
		end_frame();
	endtask

	// Value goes out least significant byte first
	task automatic send_write_reg(input logic [7:0] addr, input logic [31:0] value);
		send_byte(8'hAA);
		send_byte(8'h06);
		send_byte(8'h04);
		send_byte(addr);
		for (int i = 0; i < 4; i++) begin
			send_byte(value[8*i +: 8]);
		end
		end_frame();
	endtask

	task automatic program_seq(input int seq, input logic [31:0] init_c,
		input logic [31:0] high_c, input logic [31:0] low_c);
		send_write_reg(8'(4 * seq + 0), init_c);
		send_write_reg(8'(4 * seq + 1), high_c);
		send_write_reg(8'(4 * seq + 2), low_c);
	endtask

	task automatic measure_widths(input int ch, output int hi_w, output int lo_w);
		// Line up on a rising edge first
		while (laser_en[ch] !== 1'b0) @(posedge clk);
		while (laser_en[ch] !== 1'b1) @(posedge clk);
		hi_w = 0;
		while (laser_en[ch] === 1'b1) begin
			hi_w++;
			@(posedge clk);
		end
		lo_w = 0;
		while (laser_en[ch] === 1'b0) begin
			lo_w++;
			@(posedge clk);
		end
	endtask

	task automatic check_seq(input int ch, input int high_c, input int low_c);
		int hi_w;
		int lo_w;
		measure_widths(ch, hi_w, lo_w);
		if (hi_w != high_c) flag_mismatch($sformatf("laser_en[%0d] high width", ch), hi_w, high_c);
		if (lo_w != low_c) flag_mismatch($sformatf("laser_en[%0d] low width", ch), lo_w, low_c);
	endtask

	// Four-phase receive of one byte
	task automatic recv_byte(output logic [7:0] b);
		while (data_rdy !== 1'b1) @(posedge clk);
		b = data;
		data_ack <= 1'b1;
		@(posedge clk);
		while (data_rdy !== 1'b0) @(posedge clk);
		data_ack <= 1'b0;
		@(posedge clk);
	endtask

	task automatic recv_record(output logic [31:0] rec);
		logic [7:0] b;
		rec = '0;
		for (int i = 0; i < 4; i++) begin
			recv_byte(b);
			rec = {rec[23:0], b};
		end
	endtask

	task automatic expect_quiet(input int n, input string msg);
		repeat (n) begin
			@(posedge clk);
			if (data_rdy !== 1'b0) flag_error(msg);
		end
	endtask

	// Receiver holds ack so the byte and a low data_rdy must not move
	task automatic hold_tick(input logic [7:0] held);
		@(posedge clk);
		if (data !== held) flag_mismatch("data", data, held);
		if (data_rdy !== 1'b0) flag_mismatch("data_rdy", data_rdy, 0);
	endtask

	task automatic test_reset();
		int start;
		start = errors;
		tick(1);
		if (data_rdy !== 1'b0) flag_mismatch("data_rdy", data_rdy, 0);
		if (laser_en !== '0) flag_mismatch("laser_en", laser_en, 0);
		if (overflow !== 1'b0) flag_mismatch("overflow", overflow, 0);
		repeat (3) begin
			strobe_in <= 4'hF;
			tick(1);
			strobe_in <= 4'h0;
			tick(2);
		end
		expect_quiet(30, "byte offered while the tagger was stopped");
		finish_test("reset_state", start);
	endtask

	task automatic test_pulse();
		int start;
		start = errors;
		program_seq(0, 5, 3, 4);
		program_seq(1, 2, 6, 2);
		send_set_run(8'h02);
		check_seq(0, 3, 4);
		check_seq(1, 6, 2);
		send_set_run(8'h00);
		tick(4);
		if (laser_en !== '0) flag_mismatch("laser_en", laser_en, 0);
		finish_test("pulse_sequencer", start);
	endtask

	task automatic test_tagging();
		int          gaps [5];
		logic [3:0]  masks [5];
		logic [31:0] rec;
		logic [27:0] prev_ts;
		logic [27:0] delta;
		int          start;
		start = errors;
		prev_ts = '0;
		send_set_run(8'h01);
		tick(4);
		for (int k = 0; k < 5; k++) begin
			masks[k] = 4'b1 << (k % 4);
			gaps[k] = 2 + int'($unsigned($random(seed)) % 8);
		end
		for (int k = 0; k < 5; k++) begin
			strobe_in <= masks[k];
			tick(1);
			strobe_in <= 4'h0;
			tick(gaps[k] - 1);
		end
		for (int k = 0; k < 5; k++) begin
			recv_record(rec);
			if (rec[31:28] !== masks[k]) flag_mismatch("record chan", rec[31:28], masks[k]);
			delta = rec[27:0] - prev_ts;
			if (k > 0 && delta !== 28'(gaps[k-1])) begin
				flag_mismatch("timestamp delta", delta, gaps[k-1]);
			end
			prev_ts = rec[27:0];
		end
		// Same-cycle edges on two channels
		strobe_in <= 4'b0110;
		tick(1);
		strobe_in <= 4'h0;
		recv_record(rec);
		if (rec[31:28] !== 4'b0110) flag_mismatch("record chan", rec[31:28], 4'b0110);
		expect_quiet(20, "extra record after the paired strobes");
		finish_test("tagging", start);
	endtask

	task automatic test_malformed();
		int start;
		start = errors;
		// Wrong sync byte makes the parser skip the rest
		send_byte(8'h55);
		send_byte(8'h06);
		send_byte(8'h04);
		send_byte(8'h01);
		send_byte(8'h09);
		send_byte(8'h00);
		send_byte(8'h00);
		send_byte(8'h00);
		// Unknown opcode whose payload hides a WRITE_REG frame
		send_byte(8'hAA);
		send_byte(8'h0A);
		send_byte(8'h03);
		send_byte(8'hAA);
		send_byte(8'h06);
		send_byte(8'h04);
		send_byte(8'h01);
		send_byte(8'h09);
		send_byte(8'h00);
		send_byte(8'h00);
		send_byte(8'h00);
		send_byte(8'h00);
		// WRITE_REG with a length of five
		send_byte(8'hAA);
		send_byte(8'h05);
		send_byte(8'h04);
		send_byte(8'h01);
		send_byte(8'h09);
		send_byte(8'h00);
		send_byte(8'h00);
		end_frame();
		send_set_run(8'h02);
		check_seq(0, 3, 4);
		check_seq(1, 6, 2);
		send_set_run(8'h00);
		tick(4);
		finish_test("malformed_commands", start);
	endtask

	task automatic test_backpressure();
		logic [7:0]  held;
		logic [7:0]  b;
		logic [31:0] rec;
		logic [27:0] prev_ts;
		logic [27:0] delta;
		int          start;
		start = errors;
		prev_ts = '0;
		send_set_run(8'h01);
		tick(4);
		// First record goes into the serializer
		strobe_in <= 4'h8;
		tick(1);
		strobe_in <= 4'h0;
		while (data_rdy !== 1'b1) @(posedge clk);
		held = data;
		data_ack <= 1'b1;
		@(posedge clk);
		while (data_rdy !== 1'b0) @(posedge clk);
		for (int k = 1; k <= FIFO_DEPTH + 2; k++) begin
			strobe_in <= 4'b1 << (k % 4);
			hold_tick(held);
			strobe_in <= 4'h0;
			hold_tick(held);
			hold_tick(held);
		end
		repeat (6) hold_tick(held);
		if (overflow !== 1'b1) flag_mismatch("overflow", overflow, 1);
		data_ack <= 1'b0;
		rec = {24'h0, held};
		for (int i = 1; i < 4; i++) begin
			recv_byte(b);
			rec = {rec[23:0], b};
		end
		if (rec[31:28] !== 4'h8) flag_mismatch("record chan", rec[31:28], 4'h8);
		for (int k = 1; k <= FIFO_DEPTH; k++) begin
			recv_record(rec);
			if (rec[31:28] !== 4'(4'b1 << (k % 4))) begin
				flag_mismatch("record chan", rec[31:28], 4'b1 << (k % 4));
			end
			delta = rec[27:0] - prev_ts;
			if (k > 1 && delta !== 28'd3) flag_mismatch("timestamp delta", delta, 3);
			prev_ts = rec[27:0];
		end
		expect_quiet(20, "record past the FIFO depth was not dropped");
		finish_test("back_pressure", start);
	endtask

	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		cmd_wr       = 1'b0;
		cmd_in       = 8'h00;
		strobe_in    = 4'h0;
		data_ack     = 1'b0;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		seed         = 32'h16d7_dd6f;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		test_reset();
		test_pulse();
		test_tagging();
		test_malformed();
		test_backpressure();
		$display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
